/* verilog.f */
verilog/axi_xbar_pkg.sv
verilog/rr_arbiter.sv
verilog/xbar_slave_port.sv
verilog/xbar_master_port.sv
verilog/axi_xbar_wr.sv
sim/axi_xbar_wr_checker.sv
sim/axi_xbar_wr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the write crossbar simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module axi_xbar_wr_tb \
    --Mdir obj_dir -o axi_xbar_wr_sim

./obj_dir/axi_xbar_wr_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* sim/axi_xbar_wr_tb.sv */
// Testbench for the AXI4 write crossbar with master-side responders and directed tests
`timescale 1ns/1ps

module axi_xbar_wr_tb;
    import axi_xbar_pkg::*;

    localparam int TEST_COUNT = 5;
    localparam int TEST_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'h66bf_20b2;

    logic                 clk;
    logic                 rst;
    s_aw_t                s_aw [S_COUNT];
    logic [S_COUNT-1:0]   s_awvalid;
    logic [S_COUNT-1:0]   s_awready;
    w_beat_t              s_w [S_COUNT];
    logic [S_COUNT-1:0]   s_wvalid;
    logic [S_COUNT-1:0]   s_wready;
    s_b_t                 s_b [S_COUNT];
    logic [S_COUNT-1:0]   s_bvalid;
    logic [S_COUNT-1:0]   s_bready;
    m_aw_t                m_aw [M_COUNT];
    logic [M_COUNT-1:0]   m_awvalid;
    logic [M_COUNT-1:0]   m_awready;
    w_beat_t              m_w [M_COUNT];
    logic [M_COUNT-1:0]   m_wvalid;
    logic [M_COUNT-1:0]   m_wready;
    m_b_t                 m_b [M_COUNT];
    logic [M_COUNT-1:0]   m_bvalid;
    logic [M_COUNT-1:0]   m_bready;

    // Traffic seen at the master ports and the slave B channels
    m_aw_t   aw_log [M_COUNT][$];
    w_beat_t w_log [M_COUNT][$];
    s_b_t    b_log [S_COUNT][$];
    m_id_t   pend_id [M_COUNT][$];
    m_id_t   b_todo [M_COUNT][$];
    logic    b_fire [M_COUNT];
    logic    hold_b [M_COUNT];
    int      b_wait [M_COUNT];
    // Expected traffic per slave
    s_aw_t   exp_aw [S_COUNT][$];
    w_beat_t sent_w [S_COUNT][$];
    s_b_t    exp_b [S_COUNT][$];
    int      errors;

    axi_xbar_wr u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TEST_COUNT * TEST_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, a test did not complete", TEST_COUNT * TEST_CYCLES);
        $display("sim failed");
        $finish;
    end

    // Sample at the falling edge where everything has settled
    always @(negedge clk) begin
        for (int m = 0; m < M_COUNT; m++) begin
            b_fire[m] = !rst && m_bvalid[m] && m_bready[m];
            if (!rst && m_awvalid[m] && m_awready[m]) begin
                aw_log[m].push_back(m_aw[m]);
                pend_id[m].push_back(m_aw[m].id);
            end
            if (!rst && m_wvalid[m] && m_wready[m]) begin
                w_log[m].push_back(m_w[m]);
                if (m_w[m].last && pend_id[m].size() != 0) begin
                    b_todo[m].push_back(pend_id[m].pop_front());
                end
            end
        end
        for (int s = 0; s < S_COUNT; s++) begin
            if (!rst && s_bvalid[s] && s_bready[s]) begin
                b_log[s].push_back(s_b[s]);
            end
        end
    end

    // Master-side responders, OKAY with the same ID after a random delay
    always @(posedge clk) begin
        m_id_t next_id;
        for (int m = 0; m < M_COUNT; m++) begin
            if (rst) begin
                m_awready[m] <= 1'b0;
                m_wready[m] <= 1'b0;
                m_bvalid[m] <= 1'b0;
                b_wait[m] <= 0;
            end else begin
                m_awready[m] <= 1'b1;
                m_wready[m] <= $urandom_range(3, 0) != 0;
                if (m_bvalid[m] && b_fire[m]) begin
                    m_bvalid[m] <= 1'b0;
                    b_wait[m] <= $urandom_range(3, 0);
                end else if (!m_bvalid[m]) begin
                    if (b_wait[m] != 0) begin
                        b_wait[m] <= b_wait[m] - 1;
                    end else if (b_todo[m].size() != 0 && !hold_b[m]) begin
                        next_id = b_todo[m].pop_front();
                        m_b[m] <= '{id: next_id, resp: RESP_OKAY};
                        m_bvalid[m] <= 1'b1;
                    end
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        assert (expected === actual) else begin
            errors++;
            $display("** Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("Check failed: %s", msg);
        end
    endtask

    task automatic send_write(input int s, input s_id_t id, input addr_t addr, input int beats);
        s_aw_t   cmd;
        s_b_t    resp;
        w_beat_t beat;
        logic    routed;
        cmd = '{id: id, addr: addr, len: len_t'(beats - 1)};
        // Regions 0 and 1 belong to the masters, the rest is unmapped
        routed = addr[ADDR_W-1:REGION_W] < M_COUNT;
        resp = '{id: id, resp: routed ? RESP_OKAY : RESP_DECERR};
        if (routed) begin
            exp_aw[s].push_back(cmd);
        end
        exp_b[s].push_back(resp);
        @(posedge clk);
        s_aw[s] <= cmd;
        s_awvalid[s] <= 1'b1;
        do @(negedge clk); while (!s_awready[s]);
        @(posedge clk);
        s_awvalid[s] <= 1'b0;
        for (int b = 0; b < beats; b++) begin
            beat.data = $urandom;
            beat.strb = strb_t'($urandom);
            beat.last = b == beats - 1;
            if (routed) begin
                sent_w[s].push_back(beat);
            end
            s_w[s] <= beat;
            s_wvalid[s] <= 1'b1;
            do @(negedge clk); while (!s_wready[s]);
            @(posedge clk);
        end
        s_wvalid[s] <= 1'b0;
    endtask

    task automatic wait_b(input int s, input int n);
        for (int i = 0; i < 1000 && b_log[s].size() < n; i++) begin
            @(negedge clk);
        end
        check_true(b_log[s].size() >= n,
                   $sformatf("slave %0d got %0d write responses, expected %0d",
                             s, b_log[s].size(), n));
    endtask

    task automatic check_master(input int m);
        m_aw_t   aw;
        s_aw_t   cmd;
        w_beat_t beat;
        w_beat_t exp_w;
        int      p;
        int      k;
        k = 0;
        for (int i = 0; i < aw_log[m].size(); i++) begin
            aw = aw_log[m][i];
            p = int'(aw.id[M_ID_W-1]);
            if (exp_aw[p].size() == 0) begin
                check_true(1'b0, $sformatf("master %0d got an AW nobody sent", m));
            end else begin
                cmd = exp_aw[p].pop_front();
                check_true(int'(cmd.addr[ADDR_W-1:REGION_W]) == m,
                           $sformatf("AW for address %h reached master %0d", cmd.addr, m));
                check_val("m_aw.id", {p[0], cmd.id}, aw.id);
                check_val("m_aw.addr", cmd.addr, aw.addr);
                check_val("m_aw.len", cmd.len, aw.len);
                for (int b = 0; b <= int'(cmd.len) && k < w_log[m].size(); b++) begin
                    beat = w_log[m][k];
                    k++;
                    exp_w = sent_w[p].pop_front();
                    check_val("m_w.data", exp_w.data, beat.data);
                    check_val("m_w.strb", exp_w.strb, beat.strb);
                    check_val("m_w.last", exp_w.last, beat.last);
                end
            end
        end
        check_true(k == w_log[m].size(),
                   $sformatf("master %0d saw %0d W beats, bursts cover %0d",
                             m, w_log[m].size(), k));
    endtask

    task automatic finish_test();
        for (int s = 0; s < S_COUNT; s++) begin
            wait_b(s, exp_b[s].size());
        end
        for (int m = 0; m < M_COUNT; m++) begin
            check_master(m);
            aw_log[m].delete();
            w_log[m].delete();
        end
        for (int s = 0; s < S_COUNT; s++) begin
            for (int i = 0; i < b_log[s].size() && i < exp_b[s].size(); i++) begin
                check_val("s_b.id", exp_b[s][i].id, b_log[s][i].id);
                check_val("s_b.resp", exp_b[s][i].resp, b_log[s][i].resp);
            end
            check_true(b_log[s].size() == exp_b[s].size(),
                       $sformatf("slave %0d got extra write responses", s));
            check_true(exp_aw[s].size() == 0,
                       $sformatf("an AW from slave %0d never reached a master", s));
            exp_aw[s].delete();
            sent_w[s].delete();
            exp_b[s].delete();
            b_log[s].delete();
        end
    endtask

    task automatic test_routing();
        send_write(0, 4'h5, 32'h0000_0100, 4);
        finish_test();
    endtask

    task automatic test_crossed();
        fork
            send_write(1, 4'h2, 32'h0000_0040, 3);
            send_write(0, 4'ha, 32'h0001_0080, 2);
        join
        finish_test();
    endtask

    task automatic test_decode_error();
        send_write(0, 4'h9, 32'h0002_0000, 2);
        check_true(b_log[0].size() == 0,
                   "decode-error response arrived before the last W beat");
        finish_test();
    endtask

    task automatic test_contention();
        fork
            begin
                for (int r = 0; r < 4; r++) begin
                    send_write(0, s_id_t'(r), addr_t'(32'h0001_0000 + 64 * r), 2);
                end
            end
            begin
                for (int r = 0; r < 4; r++) begin
                    send_write(1, s_id_t'(8 + r), addr_t'(32'h0001_1000 + 64 * r), 5);
                end
            end
        join
        wait_b(0, 4);
        wait_b(1, 4);
        for (int i = 1; i < aw_log[1].size(); i++) begin
            check_true(aw_log[1][i].id[M_ID_W-1] != aw_log[1][i-1].id[M_ID_W-1],
                       $sformatf("master 1 granted the same slave twice at AW %0d", i));
        end
        finish_test();
    endtask

    task automatic test_issue_limit();
        s_b_t held;
        @(posedge clk);
        hold_b[0] <= 1'b1;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send_write(0, s_id_t'(i), addr_t'(32'h0000_0200 + 4 * i), 1);
                end
            end
            begin
                for (int i = 0; i < 1000 && aw_log[0].size() < M_ISSUE; i++) begin
                    @(negedge clk);
                end
                repeat (30) @(negedge clk);
                check_true(aw_log[0].size() == M_ISSUE,
                           $sformatf("master 0 took %0d AWs with no B returned",
                                     aw_log[0].size()));
                @(posedge clk);
                s_bready[0] <= 1'b0;
                hold_b[0] <= 1'b0;
                for (int i = 0; i < 100 && !s_bvalid[0]; i++) begin
                    @(negedge clk);
                end
                held = s_b[0];
                repeat (8) begin
                    @(negedge clk);
                    check_val("s_bvalid", 1'b1, s_bvalid[0]);
                    check_val("s_b", held, s_b[0]);
                end
                @(posedge clk);
                s_bready[0] <= 1'b1;
            end
        join
        finish_test();
    endtask

    initial begin
        void'($urandom(SEED));
        errors = 0;
        rst = 1'b1;
        s_awvalid = '0;
        s_wvalid = '0;
        s_bready = '1;
        m_awready = '0;
        m_wready = '0;
        m_bvalid = '0;
        for (int i = 0; i < 2; i++) begin
            s_aw[i] = '0;
            s_w[i] = '0;
            m_b[i] = '0;
            b_fire[i] = 1'b0;
            hold_b[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_routing();
        test_crossed();
        test_decode_error();
        test_contention();
        test_issue_limit();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sim/axi_xbar_wr_checker.sv */
// Handshake checker for the write crossbar top level, bound to axi_xbar_wr
`timescale 1ns/1ps

module axi_xbar_wr_checker (
    input logic                                clk,
    input logic                                rst,
    input axi_xbar_pkg::s_aw_t                 s_aw [axi_xbar_pkg::S_COUNT],
    input logic [axi_xbar_pkg::S_COUNT-1:0]    s_awvalid,
    input logic [axi_xbar_pkg::S_COUNT-1:0]    s_awready,
    input axi_xbar_pkg::w_beat_t               s_w [axi_xbar_pkg::S_COUNT],
    input logic [axi_xbar_pkg::S_COUNT-1:0]    s_wvalid,
    input logic [axi_xbar_pkg::S_COUNT-1:0]    s_wready,
    input axi_xbar_pkg::s_b_t                  s_b [axi_xbar_pkg::S_COUNT],
    input logic [axi_xbar_pkg::S_COUNT-1:0]    s_bvalid,
    input logic [axi_xbar_pkg::S_COUNT-1:0]    s_bready,
    input axi_xbar_pkg::m_aw_t                 m_aw [axi_xbar_pkg::M_COUNT],
    input logic [axi_xbar_pkg::M_COUNT-1:0]    m_awvalid,
    input logic [axi_xbar_pkg::M_COUNT-1:0]    m_awready,
    input axi_xbar_pkg::w_beat_t               m_w [axi_xbar_pkg::M_COUNT],
    input logic [axi_xbar_pkg::M_COUNT-1:0]    m_wvalid,
    input logic [axi_xbar_pkg::M_COUNT-1:0]    m_wready,
    input axi_xbar_pkg::m_b_t                  m_b [axi_xbar_pkg::M_COUNT],
    input logic [axi_xbar_pkg::M_COUNT-1:0]    m_bvalid,
    input logic [axi_xbar_pkg::M_COUNT-1:0]    m_bready
);
    import axi_xbar_pkg::*;

    // Valid and payload hold until the transfer on every channel
    for (genvar s = 0; s < S_COUNT; s++) begin : g_slv
        a_s_aw: assert property (@(posedge clk) disable iff (rst)
            s_awvalid[s] && !s_awready[s] |=> s_awvalid[s] && $stable(s_aw[s]))
            else $error("slave AW dropped before ready");
        a_s_w: assert property (@(posedge clk) disable iff (rst)
            s_wvalid[s] && !s_wready[s] |=> s_wvalid[s] && $stable(s_w[s]))
            else $error("slave W dropped before ready");
        a_s_b: assert property (@(posedge clk) disable iff (rst)
            s_bvalid[s] && !s_bready[s] |=> s_bvalid[s] && $stable(s_b[s]))
            else $error("slave B dropped before ready");
    end

    for (genvar m = 0; m < M_COUNT; m++) begin : g_mst
        a_m_aw: assert property (@(posedge clk) disable iff (rst)
            m_awvalid[m] && !m_awready[m] |=> m_awvalid[m] && $stable(m_aw[m]))
            else $error("master AW dropped before ready");
        a_m_w: assert property (@(posedge clk) disable iff (rst)
            m_wvalid[m] && !m_wready[m] |=> m_wvalid[m] && $stable(m_w[m]))
            else $error("master W dropped before ready");
        a_m_b: assert property (@(posedge clk) disable iff (rst)
            m_bvalid[m] && !m_bready[m] |=> m_bvalid[m] && $stable(m_b[m]))
            else $error("master B dropped before ready");
    end

    // Registers settle after the first reset edge
    a_rst_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !(|s_bvalid) && !(|m_awvalid) && !(|m_wvalid))
        else $error("valid output high during reset");

endmodule

bind axi_xbar_wr axi_xbar_wr_checker u_chk (.*);

/* verilog/axi_xbar_wr.sv */
// AXI4 write crossbar top level joining the slave and master port blocks
`timescale 1ns/1ps

module axi_xbar_wr (
    input  logic                                clk,
    input  logic                                rst,
    input  axi_xbar_pkg::s_aw_t                 s_aw [axi_xbar_pkg::S_COUNT],
    input  logic [axi_xbar_pkg::S_COUNT-1:0]    s_awvalid,
    output logic [axi_xbar_pkg::S_COUNT-1:0]    s_awready,
    input  axi_xbar_pkg::w_beat_t               s_w [axi_xbar_pkg::S_COUNT],
    input  logic [axi_xbar_pkg::S_COUNT-1:0]    s_wvalid,
    output logic [axi_xbar_pkg::S_COUNT-1:0]    s_wready,
    output axi_xbar_pkg::s_b_t                  s_b [axi_xbar_pkg::S_COUNT],
    output logic [axi_xbar_pkg::S_COUNT-1:0]    s_bvalid,
    input  logic [axi_xbar_pkg::S_COUNT-1:0]    s_bready,
    output axi_xbar_pkg::m_aw_t                 m_aw [axi_xbar_pkg::M_COUNT],
    output logic [axi_xbar_pkg::M_COUNT-1:0]    m_awvalid,
    input  logic [axi_xbar_pkg::M_COUNT-1:0]    m_awready,
    output axi_xbar_pkg::w_beat_t               m_w [axi_xbar_pkg::M_COUNT],
    output logic [axi_xbar_pkg::M_COUNT-1:0]    m_wvalid,
    input  logic [axi_xbar_pkg::M_COUNT-1:0]    m_wready,
    input  axi_xbar_pkg::m_b_t                  m_b [axi_xbar_pkg::M_COUNT],
    input  logic [axi_xbar_pkg::M_COUNT-1:0]    m_bvalid,
    output logic [axi_xbar_pkg::M_COUNT-1:0]    m_bready
);
    import axi_xbar_pkg::*;

    // Request and grant vectors seen from each side, transposed below
    wire [M_COUNT-1:0] aw_req_s [S_COUNT];
    wire [S_COUNT-1:0] aw_req_m [M_COUNT];
    wire [M_COUNT-1:0] aw_gnt_s [S_COUNT];
    wire [S_COUNT-1:0] aw_gnt_m [M_COUNT];
    wire [M_COUNT-1:0] w_req_s [S_COUNT];
    wire [S_COUNT-1:0] w_req_m [M_COUNT];
    wire [M_COUNT-1:0] w_gnt_s [S_COUNT];
    wire [S_COUNT-1:0] w_gnt_m [M_COUNT];
    wire [M_COUNT-1:0] b_req_s [S_COUNT];
    wire [S_COUNT-1:0] b_req_m [M_COUNT];
    wire [M_COUNT-1:0] b_ack_s [S_COUNT];
    wire [S_COUNT-1:0] b_ack_m [M_COUNT];
    m_b_t              b_fwd [M_COUNT];

    for (genvar s = 0; s < S_COUNT; s++) begin : g_cross_s
        for (genvar m = 0; m < M_COUNT; m++) begin : g_cross_m
            assign aw_req_m[m][s] = aw_req_s[s][m];
            assign aw_gnt_s[s][m] = aw_gnt_m[m][s];
            assign w_req_m[m][s] = w_req_s[s][m];
            assign w_gnt_s[s][m] = w_gnt_m[m][s];
            assign b_req_s[s][m] = b_req_m[m][s];
            assign b_ack_m[m][s] = b_ack_s[s][m];
        end
    end

    for (genvar s = 0; s < S_COUNT; s++) begin : g_slv
        xbar_slave_port #(.S_INDEX(s)) u_slv (
            .clk(clk), .rst(rst),
            .s_aw(s_aw[s]), .s_awvalid(s_awvalid[s]), .s_awready(s_awready[s]),
            .s_w(s_w[s]), .s_wvalid(s_wvalid[s]), .s_wready(s_wready[s]),
            .s_b(s_b[s]), .s_bvalid(s_bvalid[s]), .s_bready(s_bready[s]),
            .aw_req(aw_req_s[s]), .aw_gnt(aw_gnt_s[s]),
            .w_req(w_req_s[s]), .w_gnt(w_gnt_s[s]),
            .b_in(b_fwd), .b_req(b_req_s[s]), .b_ack(b_ack_s[s])
        );
    end

    for (genvar m = 0; m < M_COUNT; m++) begin : g_mst
        xbar_master_port #(.M_INDEX(m)) u_mst (
            .clk(clk), .rst(rst),
            .aw_in(s_aw), .aw_req(aw_req_m[m]), .aw_gnt(aw_gnt_m[m]),
            .w_in(s_w), .w_req(w_req_m[m]), .w_gnt(w_gnt_m[m]),
            .b_out(b_fwd[m]), .b_req(b_req_m[m]), .b_ack(b_ack_m[m]),
            .m_aw(m_aw[m]), .m_awvalid(m_awvalid[m]), .m_awready(m_awready[m]),
            .m_w(m_w[m]), .m_wvalid(m_wvalid[m]), .m_wready(m_wready[m]),
            .m_b(m_b[m]), .m_bvalid(m_bvalid[m]), .m_bready(m_bready[m])
        );
    end

endmodule

/* verilog/xbar_master_port.sv */
// Master port block: AW arbitration, issue limit, W steering and B return routing
`timescale 1ns/1ps

module xbar_master_port #(
    parameter int M_INDEX = 0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  axi_xbar_pkg::s_aw_t                 aw_in [axi_xbar_pkg::S_COUNT],
    input  logic [axi_xbar_pkg::S_COUNT-1:0]    aw_req,
    output logic [axi_xbar_pkg::S_COUNT-1:0]    aw_gnt,
    input  axi_xbar_pkg::w_beat_t               w_in [axi_xbar_pkg::S_COUNT],
    input  logic [axi_xbar_pkg::S_COUNT-1:0]    w_req,
    output logic [axi_xbar_pkg::S_COUNT-1:0]    w_gnt,
    output axi_xbar_pkg::m_b_t                  b_out,
    output logic [axi_xbar_pkg::S_COUNT-1:0]    b_req,
    input  logic [axi_xbar_pkg::S_COUNT-1:0]    b_ack,
    output axi_xbar_pkg::m_aw_t                 m_aw,
    output logic                                m_awvalid,
    input  logic                                m_awready,
    output axi_xbar_pkg::w_beat_t               m_w,
    output logic                                m_wvalid,
    input  logic                                m_wready,
    input  axi_xbar_pkg::m_b_t                  m_b,
    input  logic                                m_bvalid,
    output logic                                m_bready
);
    import axi_xbar_pkg::*;

    localparam int CNT_W = $clog2(M_ISSUE + 1);

    logic [CNT_W-1:0]   issue_cnt;
    logic               at_limit;
    logic               aw_hs;
    logic               b_hs;
    logic [S_COUNT-1:0] aw_arb_req;
    logic [S_COUNT-1:0] aw_grant;
    logic               aw_grant_valid;
    s_sel_t             aw_index;
    logic               route_valid;
    s_sel_t             w_sel;
    s_sel_t             b_sel;

    assign at_limit = issue_cnt == CNT_W'(M_ISSUE);
    assign aw_arb_req = (aw_grant_valid || at_limit || route_valid) ? '0 : aw_req;

    rr_arbiter #(.PORTS(S_COUNT)) u_aw_arb (
        .clk(clk), .rst(rst), .req(aw_arb_req), .ack(aw_gnt), .grant(aw_grant),
        .grant_valid(aw_grant_valid), .grant_index(aw_index)
    );

    assign m_aw = '{id: {aw_index, aw_in[aw_index].id},
                    addr: aw_in[aw_index].addr,
                    len: aw_in[aw_index].len};
    assign m_awvalid = aw_grant_valid && aw_req[aw_index];
    assign aw_gnt = aw_grant & aw_req & {S_COUNT{m_awready}};
    assign aw_hs = m_awvalid && m_awready;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_cnt <= '0;
        end else if (aw_hs && !b_hs) begin
            issue_cnt <= issue_cnt + 1'b1;
        end else if (b_hs && !aw_hs) begin
            issue_cnt <= issue_cnt - 1'b1;
        end
    end

    // W route follows the grant and stays until the last beat passes
    always_ff @(posedge clk) begin
        if (rst) begin
            route_valid <= 1'b0;
        end else if (aw_grant_valid && !route_valid) begin
            route_valid <= 1'b1;
        end else if (m_wvalid && m_wready && m_w.last) begin
            route_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_grant_valid && !route_valid) begin
            w_sel <= aw_index;
        end
    end

    assign m_w = w_in[w_sel];
    assign m_wvalid = route_valid && w_req[w_sel];

    always_comb begin
        w_gnt = '0;
        w_gnt[w_sel] = route_valid && m_wready;
    end

    // Top ID bit names the slave that issued the write
    assign b_sel = m_b.id[M_ID_W-1];
    assign b_out = m_b;
    assign m_bready = b_ack[b_sel];
    assign b_hs = m_bvalid && m_bready;

    always_comb begin
        b_req = '0;
        b_req[b_sel] = m_bvalid;
    end

endmodule

/* verilog/xbar_slave_port.sv */
// Slave port block: address decode, W steering, decode-error responder, B arbitration
`timescale 1ns/1ps

module xbar_slave_port #(
    parameter int S_INDEX = 0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  axi_xbar_pkg::s_aw_t                 s_aw,
    input  logic                                s_awvalid,
    output logic                                s_awready,
    input  axi_xbar_pkg::w_beat_t               s_w,
    input  logic                                s_wvalid,
    output logic                                s_wready,
    output axi_xbar_pkg::s_b_t                  s_b,
    output logic                                s_bvalid,
    input  logic                                s_bready,
    output logic [axi_xbar_pkg::M_COUNT-1:0]    aw_req,
    input  logic [axi_xbar_pkg::M_COUNT-1:0]    aw_gnt,
    output logic [axi_xbar_pkg::M_COUNT-1:0]    w_req,
    input  logic [axi_xbar_pkg::M_COUNT-1:0]    w_gnt,
    input  axi_xbar_pkg::m_b_t                  b_in [axi_xbar_pkg::M_COUNT],
    input  logic [axi_xbar_pkg::M_COUNT-1:0]    b_req,
    output logic [axi_xbar_pkg::M_COUNT-1:0]    b_ack
);
    import axi_xbar_pkg::*;

    // Masters plus the local decode-error responder
    localparam int B_PORTS = M_COUNT + 1;
    localparam int B_IDX_W = $clog2(B_PORTS);

    cmd_state_t         state;
    m_sel_t             dec_sel;
    logic               dec_hit;
    m_sel_t             sel;
    logic               drop;
    logic               err_valid;
    s_id_t              err_id;
    logic               aw_hs;
    logic               w_last_hs;
    logic [B_PORTS-1:0] b_valid_all;
    logic [B_PORTS-1:0] b_arb_req;
    logic [B_PORTS-1:0] b_arb_ack;
    logic [B_PORTS-1:0] b_grant;
    logic               b_grant_valid;
    logic [B_IDX_W-1:0] b_index;

    always_comb begin
        dec_sel = '0;
        dec_hit = 1'b0;
        for (int m = 0; m < M_COUNT; m++) begin
            if (s_aw.addr[ADDR_W-1:REGION_W] == M_BASE[m][ADDR_W-1:REGION_W]) begin
                dec_sel = m_sel_t'(m);
                dec_hit = 1'b1;
            end
        end
    end

    // A dropped command is taken here without waiting on any master
    assign s_awready = (state == CMD_ADDR) && (drop || aw_gnt[sel]);
    assign s_wready = (state == CMD_DATA) && (drop || w_gnt[sel]);
    assign aw_hs = s_awvalid && s_awready;
    assign w_last_hs = s_wvalid && s_wready && s_w.last;

    always_comb begin
        aw_req = '0;
        w_req = '0;
        aw_req[sel] = (state == CMD_ADDR) && !drop;
        w_req[sel] = (state == CMD_DATA) && !drop && s_wvalid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CMD_IDLE;
            err_valid <= 1'b0;
        end else begin
            case (state)
                CMD_IDLE: begin
                    // Pending error response blocks the next command
                    if (s_awvalid && !err_valid) begin
                        state <= CMD_ADDR;
                    end
                end
                CMD_ADDR: begin
                    if (aw_hs) begin
                        state <= CMD_DATA;
                    end
                end
                CMD_DATA: begin
                    if (w_last_hs) begin
                        state <= CMD_IDLE;
                        err_valid <= drop;
                    end
                end
                default: state <= CMD_IDLE;
            endcase
            if (b_arb_ack[M_COUNT]) begin
                err_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == CMD_IDLE) begin
            sel <= dec_sel;
            drop <= !dec_hit;
        end
        if (aw_hs) begin
            err_id <= s_aw.id;
        end
    end

    // Master requests arrive already steered by the top ID bit
    assign b_valid_all = {err_valid, b_req};

    assign b_arb_req = b_valid_all & ~b_grant;
    assign b_arb_ack = b_grant & b_valid_all & {B_PORTS{s_bready}};
    assign b_ack = b_arb_ack[M_COUNT-1:0];

    rr_arbiter #(.PORTS(B_PORTS)) u_b_arb (
        .clk(clk), .rst(rst), .req(b_arb_req), .ack(b_arb_ack), .grant(b_grant),
        .grant_valid(b_grant_valid), .grant_index(b_index)
    );

    always_comb begin
        if (b_index == B_IDX_W'(M_COUNT)) begin
            s_b = '{id: err_id, resp: RESP_DECERR};
        end else begin
            // Slave index bit is stripped off the returned ID
            s_b = '{id: b_in[m_sel_t'(b_index)].id[S_ID_W-1:0],
                    resp: b_in[m_sel_t'(b_index)].resp};
        end
        s_bvalid = b_grant_valid && b_valid_all[b_index];
    end

endmodule

/* verilog/rr_arbiter.sv */
// Round-robin arbiter with a registered one-hot grant held until acknowledged
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int PORTS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [PORTS-1:0]           req,
    input  logic [PORTS-1:0]           ack,
    output logic [PORTS-1:0]           grant,
    output logic                       grant_valid,
    output logic [$clog2(PORTS)-1:0]   grant_index
);

    localparam int IDX_W = $clog2(PORTS);

    logic [PORTS-1:0] pick;
    logic [IDX_W-1:0] pick_index;
    logic             pick_found;

    // Search starts one past the last winner
    always_comb begin
        int cand;
        pick = '0;
        pick_index = '0;
        pick_found = 1'b0;
        for (int i = 1; i <= PORTS; i++) begin
            cand = (int'(grant_index) + i) % PORTS;
            if (!pick_found && req[cand]) begin
                pick[cand] = 1'b1;
                pick_index = IDX_W'(cand);
                pick_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
            grant_index <= IDX_W'(PORTS - 1);
        end else if (!grant_valid || (grant & ack) != '0) begin
            grant <= pick;
            // Index keeps the last winner once the grant drops
            if (pick_found) begin
                grant_index <= pick_index;
            end
        end
    end

    assign grant_valid = |grant;

endmodule

/* verilog/axi_xbar_pkg.sv */
// AXI4 write crossbar package with sizes, address map and channel payload types
package axi_xbar_pkg;

    localparam int S_COUNT = 2;
    localparam int M_COUNT = 2;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int S_ID_W = 4;
    // Master side carries the slave index above the original ID
    localparam int M_ID_W = S_ID_W + 1;
    localparam int M_ISSUE = 4;
    localparam int REGION_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [S_ID_W-1:0] s_id_t;
    typedef logic [M_ID_W-1:0] m_id_t;
    typedef logic [7:0]        len_t;
    typedef logic [1:0]        resp_t;
    typedef logic [0:0]        s_sel_t;
    typedef logic [0:0]        m_sel_t;

    // One 64 KiB region per master, anything outside is a decode error
    localparam addr_t M_BASE [M_COUNT] = '{32'h0000_0000, 32'h0001_0000};

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        s_id_t id;
        addr_t addr;
        len_t  len;
    } s_aw_t;

    typedef struct packed {
        m_id_t id;
        addr_t addr;
        len_t  len;
    } m_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    typedef struct packed {
        s_id_t id;
        resp_t resp;
    } s_b_t;

    typedef struct packed {
        m_id_t id;
        resp_t resp;
    } m_b_t;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_ADDR,
        CMD_DATA
    } cmd_state_t;

endpackage
